/* src/cache_defs.svh */
/*
 * cache geometry macros
 * offset, index and tag widths, set count
 */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// byte offset within a 32-byte line
`define CACHE_S_OFFSET 5

// set index
`define CACHE_S_INDEX 3

// whatever is left of a 32-bit address
`define CACHE_S_TAG (32 - `CACHE_S_OFFSET - `CACHE_S_INDEX)

// sets per way
`define CACHE_NUM_SETS (2 ** `CACHE_S_INDEX)

`endif

/* src/cache_pkg.sv */
/*
 * cache types
 * address, line, byte-enable, tag and index vectors, control states
 */
`default_nettype none

`include "cache_defs.svh"

package cache_pkg;

    typedef logic [31:0] addr_t;

    // one line, 8 bits per offset byte
    typedef logic [8*(2**`CACHE_S_OFFSET)-1:0] line_t;
    typedef logic [(2**`CACHE_S_OFFSET)-1:0] be_t;

    typedef logic [`CACHE_S_TAG-1:0] tag_t;
    typedef logic [`CACHE_S_INDEX-1:0] index_t;

    typedef enum logic [1:0] {
        s_idle,
        s_check,
        s_writeback,
        s_allocate
    } cache_state_e;

endpackage : cache_pkg

`default_nettype wire

/* src/array.sv */
/*
 * per-set metadata store for tags and flag bits
 * cleared on reset, written on load, read combinationally
 */
`timescale 1ns/10ps
`default_nettype none

`include "cache_defs.svh"

module array #(
    parameter int width = 1
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load,
    input  cache_pkg::index_t     index,
    input  logic [width-1:0]      datain,
    output logic [width-1:0]      dataout
);

    logic [width-1:0] data [`CACHE_NUM_SETS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CACHE_NUM_SETS; i++) begin
                data[i] <= '0;
            end
        end else if (load) begin
            data[index] <= datain;
        end
    end

    // no bypass, a write shows up on the next cycle
    assign dataout = data[index];

endmodule : array

`default_nettype wire

/* src/data_array.sv */
/*
 * per-set line store with byte write enables
 * combinational read, contents not reset
 */
`timescale 1ns/10ps
`default_nettype none

`include "cache_defs.svh"

module data_array (
    input  logic                clk,
    input  cache_pkg::be_t      write_en,
    input  cache_pkg::index_t   index,
    input  cache_pkg::line_t    datain,
    output cache_pkg::line_t    dataout
);

    cache_pkg::line_t data [`CACHE_NUM_SETS];

    // each enable bit owns one byte lane of the line
    always_ff @(posedge clk) begin
        for (int i = 0; i < $bits(cache_pkg::be_t); i++) begin
            if (write_en[i]) begin
                data[index][8*i +: 8] <= datain[8*i +: 8];
            end
        end
    end

    assign dataout = data[index];

endmodule : data_array

`default_nettype wire

/* src/cache_datapath.sv */
/*
 * two-way cache datapath
 * tag, valid, dirty, lru and data arrays, tag compare,
 * way select, write-data steering, memory address mux
 */
`timescale 1ns/10ps
`default_nettype none

`include "cache_defs.svh"

module cache_datapath (
    input  logic                clk,
    input  logic                rst_n,

    // cpu side
    input  cache_pkg::addr_t    mem_address,
    input  cache_pkg::line_t    mem_wdata,
    output cache_pkg::line_t    mem_rdata,

    // memory side
    input  cache_pkg::line_t    pmem_rdata,
    output cache_pkg::line_t    pmem_wdata,
    output cache_pkg::addr_t    pmem_address,

    // status to control
    output logic                hit,
    output logic                dirty,

    // commands from control
    input  logic                tag_load,
    input  logic                valid_load,
    input  logic                dirty_load,
    input  logic                lru_load,
    input  cache_pkg::be_t      data_write_en,
    input  logic                pmem_addr_sel
);

    // address fields
    cache_pkg::tag_t    tag;
    cache_pkg::index_t  index;

    // array outputs
    cache_pkg::tag_t    tag0_out;
    cache_pkg::tag_t    tag1_out;
    logic               valid0_out;
    logic               valid1_out;
    logic               dirty0_out;
    logic               dirty1_out;
    logic               lru;
    cache_pkg::line_t   data0_out;
    cache_pkg::line_t   data1_out;

    // compare and steering
    logic               hit0;
    logic               hit1;
    logic               way_sel;
    cache_pkg::tag_t    victim_tag;
    cache_pkg::line_t   data_in;
    logic               dirty_in;
    cache_pkg::be_t     data0_write_en;
    cache_pkg::be_t     data1_write_en;

    assign tag   = mem_address[31 -: `CACHE_S_TAG];
    assign index = mem_address[`CACHE_S_OFFSET +: `CACHE_S_INDEX];

    array #(.width(`CACHE_S_TAG)) tag_way0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (tag_load & ~way_sel),
        .index   (index),
        .datain  (tag),
        .dataout (tag0_out)
    );

    array #(.width(`CACHE_S_TAG)) tag_way1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (tag_load & way_sel),
        .index   (index),
        .datain  (tag),
        .dataout (tag1_out)
    );

    array #(.width(1)) valid_way0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (valid_load & ~way_sel),
        .index   (index),
        .datain  (1'b1),
        .dataout (valid0_out)
    );

    array #(.width(1)) valid_way1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (valid_load & way_sel),
        .index   (index),
        .datain  (1'b1),
        .dataout (valid1_out)
    );

    array #(.width(1)) dirty_way0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (dirty_load & ~way_sel),
        .index   (index),
        .datain  (dirty_in),
        .dataout (dirty0_out)
    );

    array #(.width(1)) dirty_way1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (dirty_load & way_sel),
        .index   (index),
        .datain  (dirty_in),
        .dataout (dirty1_out)
    );

    // lru bit names the way to replace next
    array #(.width(1)) lru_bits (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (lru_load),
        .index   (index),
        .datain  (~way_sel),
        .dataout (lru)
    );

    data_array data_way0 (
        .clk      (clk),
        .write_en (data0_write_en),
        .index    (index),
        .datain   (data_in),
        .dataout  (data0_out)
    );

    data_array data_way1 (
        .clk      (clk),
        .write_en (data1_write_en),
        .index    (index),
        .datain   (data_in),
        .dataout  (data1_out)
    );

    // tag compare, qualified by valid
    assign hit0 = valid0_out && (tag0_out == tag);
    assign hit1 = valid1_out && (tag1_out == tag);
    assign hit  = hit0 | hit1;

    // hitting way on a hit, else the replacement candidate
    assign way_sel = hit ? hit1 : lru;

    assign victim_tag = way_sel ? tag1_out : tag0_out;
    assign dirty      = way_sel ? dirty1_out : dirty0_out;
    assign mem_rdata  = way_sel ? data1_out : data0_out;
    assign pmem_wdata = way_sel ? data1_out : data0_out;

    // cpu data on a write hit, memory data on a fill
    assign data_in  = hit ? mem_wdata : pmem_rdata;
    assign dirty_in = hit;

    assign data0_write_en = way_sel ? '0 : data_write_en;
    assign data1_write_en = way_sel ? data_write_en : '0;

    // line aligned, victim line during write-back
    always_comb begin
        if (pmem_addr_sel) begin
            pmem_address = {victim_tag, index, {`CACHE_S_OFFSET{1'b0}}};
        end else begin
            pmem_address = {mem_address[31:`CACHE_S_OFFSET], {`CACHE_S_OFFSET{1'b0}}};
        end
    end

endmodule : cache_datapath

`default_nettype wire

/* src/cache_control.sv */
/*
 * cache control FSM
 * sequences hits, dirty write-backs and line fills
 */
`timescale 1ns/10ps
`default_nettype none

module cache_control (
    input  logic                clk,
    input  logic                rst_n,

    // cpu side
    input  logic                mem_read,
    input  logic                mem_write,
    input  cache_pkg::be_t      mem_byte_enable,
    output logic                mem_resp,

    // memory side
    output logic                pmem_read,
    output logic                pmem_write,
    input  logic                pmem_resp,

    // datapath status
    input  logic                hit,
    input  logic                dirty,

    // datapath commands
    output logic                tag_load,
    output logic                valid_load,
    output logic                dirty_load,
    output logic                lru_load,
    output cache_pkg::be_t      data_write_en,
    output logic                pmem_addr_sel
);

    cache_pkg::cache_state_e state;
    cache_pkg::cache_state_e next_state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= cache_pkg::s_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state    = state;
        mem_resp      = 1'b0;
        pmem_read     = 1'b0;
        pmem_write    = 1'b0;
        tag_load      = 1'b0;
        valid_load    = 1'b0;
        dirty_load    = 1'b0;
        lru_load      = 1'b0;
        data_write_en = '0;
        pmem_addr_sel = 1'b0;

        case (state)
            cache_pkg::s_idle: begin
                if (mem_read || mem_write) begin
                    next_state = cache_pkg::s_check;
                end
            end

            cache_pkg::s_check: begin
                if (hit) begin
                    mem_resp   = 1'b1;
                    lru_load   = 1'b1;
                    next_state = cache_pkg::s_idle;
                    // write hit merges the enabled bytes and marks the line
                    if (mem_write) begin
                        data_write_en = mem_byte_enable;
                        dirty_load    = 1'b1;
                    end
                end else if (dirty) begin
                    next_state = cache_pkg::s_writeback;
                end else begin
                    next_state = cache_pkg::s_allocate;
                end
            end

            cache_pkg::s_writeback: begin
                pmem_write    = 1'b1;
                pmem_addr_sel = 1'b1;
                if (pmem_resp) begin
                    next_state = cache_pkg::s_allocate;
                end
            end

            cache_pkg::s_allocate: begin
                pmem_read = 1'b1;
                // fill the whole line, dirty cleared by the datapath
                if (pmem_resp) begin
                    tag_load      = 1'b1;
                    valid_load    = 1'b1;
                    dirty_load    = 1'b1;
                    data_write_en = '1;
                    next_state    = cache_pkg::s_check;
                end
            end

            default: begin
                next_state = cache_pkg::s_idle;
            end
        endcase
    end

endmodule : cache_control

`default_nettype wire

/* src/cache.sv */
/*
 * cache top level
 * control FSM and datapath between cpu and memory ports
 */
`timescale 1ns/10ps
`default_nettype none

module cache (
    input  logic                clk,
    input  logic                rst_n,

    // cpu port
    input  logic                mem_read,
    input  logic                mem_write,
    input  cache_pkg::addr_t    mem_address,
    input  cache_pkg::line_t    mem_wdata,
    input  cache_pkg::be_t      mem_byte_enable,
    output cache_pkg::line_t    mem_rdata,
    output logic                mem_resp,

    // memory port
    output logic                pmem_read,
    output logic                pmem_write,
    output cache_pkg::addr_t    pmem_address,
    output cache_pkg::line_t    pmem_wdata,
    input  cache_pkg::line_t    pmem_rdata,
    input  logic                pmem_resp
);

    logic             hit;
    logic             dirty;
    logic             tag_load;
    logic             valid_load;
    logic             dirty_load;
    logic             lru_load;
    cache_pkg::be_t   data_write_en;
    logic             pmem_addr_sel;

    cache_control u_control (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_byte_enable (mem_byte_enable),
        .mem_resp        (mem_resp),
        .pmem_read       (pmem_read),
        .pmem_write      (pmem_write),
        .pmem_resp       (pmem_resp),
        .hit             (hit),
        .dirty           (dirty),
        .tag_load        (tag_load),
        .valid_load      (valid_load),
        .dirty_load      (dirty_load),
        .lru_load        (lru_load),
        .data_write_en   (data_write_en),
        .pmem_addr_sel   (pmem_addr_sel)
    );

    cache_datapath u_datapath (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_address   (mem_address),
        .mem_wdata     (mem_wdata),
        .mem_rdata     (mem_rdata),
        .pmem_rdata    (pmem_rdata),
        .pmem_wdata    (pmem_wdata),
        .pmem_address  (pmem_address),
        .hit           (hit),
        .dirty         (dirty),
        .tag_load      (tag_load),
        .valid_load    (valid_load),
        .dirty_load    (dirty_load),
        .lru_load      (lru_load),
        .data_write_en (data_write_en),
        .pmem_addr_sel (pmem_addr_sel)
    );

endmodule : cache

`default_nettype wire

/* testbench/cache_checker.sv */
/*
 * port protocol assertions for the cache
 * bound into the cache top level
 */
`timescale 1ns/10ps
`default_nettype none

module cache_checker (
    input logic             clk,
    input logic             rst_n,
    input logic             mem_read,
    input logic             mem_write,
    input logic             mem_resp,
    input logic             pmem_read,
    input logic             pmem_write,
    input logic             pmem_resp,
    input cache_pkg::addr_t pmem_address,
    input cache_pkg::line_t pmem_wdata
);

    assert property (@(posedge clk) disable iff (!rst_n) !(pmem_read && pmem_write))
        else $error("pmem_read and pmem_write high together");

    assert property (@(posedge clk) disable iff (!rst_n) mem_resp |-> (mem_read || mem_write))
        else $error("mem_resp high without a cpu request");

    // memory requests hold until answered
    assert property (@(posedge clk) disable iff (!rst_n)
        (pmem_read && !pmem_resp) |=> (pmem_read && $stable(pmem_address)))
        else $error("pmem read request changed before pmem_resp");

    assert property (@(posedge clk) disable iff (!rst_n)
        (pmem_write && !pmem_resp) |=>
            (pmem_write && $stable(pmem_address) && $stable(pmem_wdata)))
        else $error("pmem write request changed before pmem_resp");

    assert property (@(posedge clk) $rose(rst_n) |-> !mem_resp)
        else $error("mem_resp high in the first cycle after reset");

endmodule : cache_checker

bind cache cache_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .mem_resp     (mem_resp),
    .pmem_read    (pmem_read),
    .pmem_write   (pmem_write),
    .pmem_resp    (pmem_resp),
    .pmem_address (pmem_address),
    .pmem_wdata   (pmem_wdata)
);

`default_nettype wire

/* testbench/cache_tb.sv */
/*
 * cache testbench
 * clock, reset, memory model with random delays,
 * golden-file request driver and compare tasks
 */
`timescale 1ns/10ps
`default_nettype none

module cache_tb;

    localparam int max_wait = 200;

    logic               clk;
    logic               rst_n;
    logic               mem_read;
    logic               mem_write;
    cache_pkg::addr_t   mem_address;
    cache_pkg::line_t   mem_wdata;
    cache_pkg::be_t     mem_byte_enable;
    cache_pkg::line_t   mem_rdata;
    logic               mem_resp;
    logic               pmem_read;
    logic               pmem_write;
    cache_pkg::addr_t   pmem_address;
    cache_pkg::line_t   pmem_wdata;
    cache_pkg::line_t   pmem_rdata;
    logic               pmem_resp;

    // memory model contents and traffic
    cache_pkg::line_t   mem_model [cache_pkg::addr_t];
    cache_pkg::addr_t   last_wb_addr = '0;
    integer             rd_count = 0;
    integer             wr_count = 0;
    integer             seed = 32'h62f58d34;

    integer             mismatch_count = 0;
    integer             failure_count = 0;

    cache u_cache (.*);

    always #50 clk = ~clk;

    // lines never preloaded read back a pattern of their own address
    function automatic cache_pkg::line_t fill_line(input cache_pkg::addr_t addr);
        fill_line = {8{addr ^ 32'h9e3779b9}};
    endfunction

    initial begin : memory_model
        integer delay_left;
        logic   busy;
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        busy       = 1'b0;
        delay_left = 0;
        forever begin
            @(negedge clk);
            if (pmem_resp) begin
                pmem_resp = 1'b0;
            end else if (pmem_read || pmem_write) begin
                if (!busy) begin
                    busy       = 1'b1;
                    delay_left = 1 + ($unsigned($random(seed)) % 4);
                end
                delay_left = delay_left - 1;
                if (delay_left == 0) begin
                    busy = 1'b0;
                    if (pmem_write) begin
                        mem_model[pmem_address] = pmem_wdata;
                        last_wb_addr = pmem_address;
                        wr_count = wr_count + 1;
                    end else begin
                        pmem_rdata = mem_model.exists(pmem_address) ?
                                     mem_model[pmem_address] : fill_line(pmem_address);
                        rd_count = rd_count + 1;
                    end
                    pmem_resp = 1'b1;
                end
            end
        end
    end

    task automatic check_line(input string name, input cache_pkg::line_t got,
                              input cache_pkg::line_t exp);
        if (got !== exp) begin
            mismatch_count = mismatch_count + 1;
            $display("mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input cache_pkg::addr_t got,
                              input cache_pkg::addr_t exp);
        if (got !== exp) begin
            mismatch_count = mismatch_count + 1;
            $display("mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input integer got, input integer exp);
        if (got !== exp) begin
            mismatch_count = mismatch_count + 1;
            $display("mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // one cpu request, held until mem_resp and through the responding edge
    task automatic run_request(input logic is_write, input cache_pkg::addr_t addr,
                               input cache_pkg::line_t wdata, input cache_pkg::be_t be,
                               output cache_pkg::line_t rdata, output logic done);
        integer waited;
        @(negedge clk);
        mem_read        = !is_write;
        mem_write       = is_write;
        mem_address     = addr;
        mem_wdata       = wdata;
        mem_byte_enable = be;
        waited = 0;
        do begin
            @(negedge clk);
            waited = waited + 1;
        end while (!mem_resp && waited < max_wait);
        done  = mem_resp;
        rdata = mem_rdata;
        if (!done) begin
            failure_count = failure_count + 1;
            $display("timeout at %0t: no mem_resp for address %h within %0d cycles",
                     $time, addr, max_wait);
        end
        @(negedge clk);
        mem_read  = 1'b0;
        mem_write = 1'b0;
    endtask

    initial begin : golden_driver
        integer           fd;
        integer           n;
        integer           op;
        integer           exp_rd;
        integer           exp_wr;
        integer           rd_base;
        integer           wr_base;
        string            text;
        logic             done;
        cache_pkg::addr_t addr;
        cache_pkg::line_t wdata;
        cache_pkg::line_t exp_rdata;
        cache_pkg::line_t got;
        cache_pkg::be_t   be;

        clk             = 1'b0;
        rst_n           = 1'b0;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_address     = '0;
        mem_wdata       = '0;
        mem_byte_enable = '0;
        done            = 1'b1;

        fd = $fopen("testbench/cache_golden.txt", "r");
        if (fd == 0) begin
            failure_count = failure_count + 1;
            $display("cannot open testbench/cache_golden.txt");
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // op 0 preload, 1 read, 2 write, 3 write-back check
        while (fd != 0 && done && !$feof(fd)) begin
            text = "";
            n = $fgets(text, fd);
            if (n > 1 && text.getc(0) != "#") begin
                n = $sscanf(text, "%h %h %h %h %h %d %d",
                            op, addr, wdata, be, exp_rdata, exp_rd, exp_wr);
                if (op == 0) begin
                    mem_model[addr] = wdata;
                end else if (op == 3) begin
                    check_addr("write-back address", last_wb_addr, addr);
                    check_line("written-back line", mem_model[addr], wdata);
                end else if (n == 7) begin
                    rd_base = rd_count;
                    wr_base = wr_count;
                    run_request(op == 2, addr, wdata, be, got, done);
                    if (done && op == 1) begin
                        check_line("mem_rdata", got, exp_rdata);
                    end
                    check_count("pmem reads", rd_count - rd_base, exp_rd);
                    check_count("pmem writes", wr_count - wr_base, exp_wr);
                end else begin
                    failure_count = failure_count + 1;
                    $display("golden line could not be parsed: %s", text);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : cache_tb

`default_nettype wire

/* testbench/cache_golden.txt */
# op addr wdata byte_enable rdata pmem_reads pmem_writes (hex, counts decimal)
# op 0 preload addr with wdata, 1 read, 2 write, 3 check last write-back addr and line
0 00000000 1111111111111111111111111111111111111111111111111111111111111111
0 00000100 2222222222222222222222222222222222222222222222222222222222222222
0 00000200 3333333333333333333333333333333333333333333333333333333333333333
0 00000020 4444444444444444444444444444444444444444444444444444444444444444
0 00000120 5555555555555555555555555555555555555555555555555555555555555555
0 00000220 6666666666666666666666666666666666666666666666666666666666666666
1 00000000 0 0 1111111111111111111111111111111111111111111111111111111111111111 1 0
1 00000000 0 0 1111111111111111111111111111111111111111111111111111111111111111 0 0
2 00000000 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 0000000f 0 0 0
1 00000000 0 0 11111111111111111111111111111111111111111111111111111111ffffffff 0 0
1 00000100 0 0 2222222222222222222222222222222222222222222222222222222222222222 1 0
1 00000000 0 0 11111111111111111111111111111111111111111111111111111111ffffffff 0 0
1 00000200 0 0 3333333333333333333333333333333333333333333333333333333333333333 1 0
1 00000100 0 0 2222222222222222222222222222222222222222222222222222222222222222 1 1
3 00000000 11111111111111111111111111111111111111111111111111111111ffffffff
1 00000000 0 0 11111111111111111111111111111111111111111111111111111111ffffffff 1 0
2 00000020 abababababababababababababababababababababababababababababababab f0000000 0 1 0
1 00000120 0 0 5555555555555555555555555555555555555555555555555555555555555555 1 0
1 00000220 0 0 6666666666666666666666666666666666666666666666666666666666666666 1 1
3 00000020 abababab44444444444444444444444444444444444444444444444444444444
1 00000020 0 0 abababab44444444444444444444444444444444444444444444444444444444 1 0

/* filelist.f */
+incdir+src
src/cache_pkg.sv
src/array.sv
src/data_array.sv
src/cache_datapath.sv
src/cache_control.sv
src/cache.sv
testbench/cache_checker.sv
testbench/cache_tb.sv

/* run.sh */
#!/bin/sh
# build the cache testbench with Verilator, run it, then judge the log
verilator --binary --timing --assert -j 0 --top-module cache_tb -f filelist.f \
    -o cache_sim || exit 1
./obj_dir/cache_sim > sim.log 2>&1
cat sim.log
grep -q "Test failures found" sim.log && echo "FAILED" && exit 1
grep -q "All tests passed!" sim.log || { echo "FAILED"; exit 1; }
echo "PASSED"
